// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_cim_ctrl
OBJ_DIR   ?= obj_dir
FILELIST  ?= sources.f
VFLAGS    ?= --binary --timing --assert
RUN_ARGS  ?= +verilator+error+limit+100
PASS_STR  ?= Result: PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_STR)"

clean:
	rm -rf $(OBJ_DIR)

// ==== include/cim_ctrl_consts.svh ====
`ifndef CIM_CTRL_CONSTS_SVH
`define CIM_CTRL_CONSTS_SVH

// Macro array and table sizes
`define CIM_MACRO_NUM           8
`define CIM_MACRO_SEL_BITS      3
`define CIM_COL_NUM             128
`define CIM_INSTR_ADDR_BITS     8
`define CIM_CNT_NUM_BITS        3
`define CIM_CNT_LEN             10
`define CIM_DDR_NUM_BITS        3
`define CIM_DDR_ADDR_LEN        25
`define CIM_INCR_BITS           7
`define CIM_LDST_CMD_BITS       7
`define CIM_COMP_CMD_BITS       25

// Instruction class, high selects the macro format
`define CIM_F_MODE              63

// Register-table format, low bit of each field
`define CIM_F_LD_STK_EN         50
`define CIM_F_LD_DDR_EN         49
`define CIM_F_LD_CNT_IDX        46
`define CIM_F_LD_DDR_IDX        43
`define CIM_F_LD_STACK          35
`define CIM_F_LD_CNT            25
`define CIM_F_LD_DDR            0

// Macro format, bits 50..48 unused
`define CIM_F_LOOP_EN           62
`define CIM_F_LOOP_IDX          59
`define CIM_F_INCR_EN           58
`define CIM_F_INCR              51
`define CIM_F_DDR_IDX           45
`define CIM_F_SEL_MODE          43
`define CIM_F_MACRO_SEL         40
`define CIM_F_LDST_CMD          33
`define CIM_F_COMP_MASK         25
`define CIM_F_COMP_CMD          0

`endif

// ==== sim/cim_ctrl_asserts.sv ====
`timescale 1ns/1ps
`include "cim_ctrl_consts.svh"

module cim_ctrl_asserts (
    input  logic                                        clk,
    input  logic                                        rst_n,
    input  logic                                        dram_valid,
    input  logic                                        dram_wr_en,
    input  cim_ctrl_pkg::col_data_t                     dram_rd_data,
    input  cim_ctrl_pkg::col_data_t                     dram_wr_data,
    input  cim_ctrl_pkg::macro_mask_t                   ex_valid,
    input  cim_ctrl_pkg::col_data_t                     ex_wr_data,
    input  cim_ctrl_pkg::col_data_t [`CIM_MACRO_NUM-1:0] ex_rd_data,
    input  cim_ctrl_pkg::macro_mask_t                   compute_valid
);

    import cim_ctrl_pkg::*;

    // Read by the testbench to end the run
    int fail_count = 0;

    // Position of the single set bit
    function automatic int onehot_index(macro_mask_t mask);
        int idx;
        idx = 0;
        for (int i = 0; i < `CIM_MACRO_NUM; i++) begin
            if (mask[i])
                idx = i;
        end
        return idx;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Strobes after reset
    a_reset_quiet: assert property (@(posedge clk)
        !rst_n |=> (!dram_valid && ex_valid == '0 && compute_valid == '0))
        else begin fail_count++; $error("strobe active right after reset"); end

    a_wr_needs_valid: assert property (@(posedge clk) disable iff (!rst_n)
        dram_wr_en |-> dram_valid)
        else begin fail_count++; $error("dram_wr_en without dram_valid"); end

    a_valid_matches_sel: assert property (@(posedge clk) disable iff (!rst_n)
        dram_valid == (ex_valid != '0))
        else begin fail_count++; $error("dram_valid disagrees with ex_valid"); end

    ////////////////////////////////////////////////////////////////////////////
    // Data paths
    a_load_data: assert property (@(posedge clk) disable iff (!rst_n)
        (dram_valid && !dram_wr_en) |-> (ex_wr_data == dram_rd_data))
        else begin fail_count++; $error("ex_wr_data differs from dram_rd_data"); end

    a_store_data: assert property (@(posedge clk) disable iff (!rst_n)
        (dram_wr_en && $onehot(ex_valid)) |->
            (dram_wr_data == ex_rd_data[onehot_index(ex_valid)]))
        else begin fail_count++; $error("dram_wr_data differs from macro read data"); end

endmodule

bind cim_ctrl_top cim_ctrl_asserts chk (.*);

// ==== sim/tb_cim_ctrl.sv ====
`timescale 1ns/1ps
`include "cim_ctrl_consts.svh"

module tb_cim_ctrl;

    import cim_ctrl_pkg::*;

    logic clk;
    logic rst_n;
    logic run;
    logic cpu_instr_valid;
    logic [`CIM_INSTR_ADDR_BITS:0] cpu_instr_addr;
    logic [31:0] cpu_instr_data;
    logic dram_valid;
    logic dram_wr_en;
    ddr_addr_t dram_addr;
    col_data_t dram_rd_data;
    col_data_t dram_wr_data;
    macro_mask_t ex_valid;
    ldst_cmd_t ex_command;
    col_data_t ex_wr_data;
    col_data_t [`CIM_MACRO_NUM-1:0] ex_rd_data;
    macro_mask_t compute_valid;
    comp_cmd_t compute_command;

    logic quiet;
    instr_t prog [16];
    macro_mask_t q_ex[$];
    ddr_addr_t q_addr[$];
    logic q_wr[$];
    ldst_cmd_t q_cmd[$];
    macro_mask_t q_cmask[$];
    comp_cmd_t q_ccmd[$];
    ddr_addr_t base_a;
    ddr_addr_t base_b;

    cim_ctrl_top dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic value_mismatch(string name, logic [63:0] got, logic [63:0] exp);
        $display("[ERROR] %0t %s: got %0h expected %0h", $time, name, got, exp);
        $display("Result: FAILED");
        $fatal(1);
    endtask

    task automatic abort_run(string what);
        $display("ERROR at %0t: %s", $time, what);
        $display("Result: FAILED");
        $fatal(1);
    endtask

    function automatic col_data_t rand_col();
        return {$urandom(), $urandom(), $urandom(), $urandom()};
    endfunction

    function automatic instr_t make_table_instr(logic stk, logic ddr, logic [2:0] cidx,
            logic [2:0] didx, pc_t tgt, counter_t cnt, ddr_addr_t val);
        instr_t w;
        w = '0;
        w[`CIM_F_LD_STK_EN] = stk;
        w[`CIM_F_LD_DDR_EN] = ddr;
        w[`CIM_F_LD_CNT_IDX +: 3] = cidx;
        w[`CIM_F_LD_DDR_IDX +: 3] = didx;
        w[`CIM_F_LD_STACK +: 8] = tgt;
        w[`CIM_F_LD_CNT +: 10] = cnt;
        w[`CIM_F_LD_DDR +: 25] = val;
        return w;
    endfunction

    function automatic instr_t make_macro_instr(logic loop, logic [2:0] lidx, logic inc,
            logic [6:0] amt, logic [2:0] didx, logic [1:0] sel, logic [2:0] msel,
            ldst_cmd_t ldst, macro_mask_t cmask, comp_cmd_t ccmd);
        instr_t w;
        w = '0;
        w[`CIM_F_MODE] = 1'b1;
        w[`CIM_F_LOOP_EN] = loop;
        w[`CIM_F_LOOP_IDX +: 3] = lidx;
        w[`CIM_F_INCR_EN] = inc;
        w[`CIM_F_INCR +: 7] = amt;
        w[`CIM_F_DDR_IDX +: 3] = didx;
        w[`CIM_F_SEL_MODE +: 2] = sel;
        w[`CIM_F_MACRO_SEL +: 3] = msel;
        w[`CIM_F_LDST_CMD +: 7] = ldst;
        w[`CIM_F_COMP_MASK +: 8] = cmask;
        w[`CIM_F_COMP_CMD +: 25] = ccmd;
        return w;
    endfunction

    // Two half writes per entry with the low half first
    task automatic write_entry(int idx, instr_t w);
        @(posedge clk);
        cpu_instr_valid <= 1'b1;
        cpu_instr_addr <= {pc_t'(idx), 1'b0};
        cpu_instr_data <= w[31:0];
        @(posedge clk);
        cpu_instr_addr <= {pc_t'(idx), 1'b1};
        cpu_instr_data <= w[63:32];
        @(posedge clk);
        cpu_instr_valid <= 1'b0;
    endtask

    task automatic apply_reset();
        rst_n <= 1'b0;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
    endtask

    // Run from entry 0 until the expected strobes have been seen
    task automatic run_program(int n_dram, int n_comp);
        int waited;
        for (int i = 0; i < 16; i++)
            write_entry(i, prog[i]);
        apply_reset();
        q_ex.delete();
        q_addr.delete();
        q_wr.delete();
        q_cmd.delete();
        q_cmask.delete();
        q_ccmd.delete();
        quiet <= 1'b0;
        run <= 1'b1;
        waited = 0;
        while (q_ex.size() < n_dram || q_cmask.size() < n_comp) begin
            @(posedge clk);
            waited++;
            if (waited > 200)
                abort_run("timeout waiting for DUT strobes");
        end
        // Window to catch any extra strobes
        repeat (12) @(posedge clk);
        run <= 1'b0;
        repeat (4) @(posedge clk);
        quiet <= 1'b1;
        @(posedge clk);
        if (q_ex.size() != n_dram)
            abort_run("wrong number of DRAM transfers");
        if (q_cmask.size() != n_comp)
            abort_run("wrong number of compute strobes");
    endtask

    // Random DRAM and macro read data
    always @(posedge clk) begin
        dram_rd_data <= rand_col();
        for (int i = 0; i < `CIM_MACRO_NUM; i++)
            ex_rd_data[i] <= rand_col();
    end

    // Strobe monitor
    always @(posedge clk) begin
        if (quiet) begin
            assert (!dram_valid && ex_valid == '0 && compute_valid == '0)
                else abort_run("output strobe active while idle");
        end
        if (dram_valid) begin
            q_ex.push_back(ex_valid);
            q_addr.push_back(dram_addr);
            q_wr.push_back(dram_wr_en);
            q_cmd.push_back(ex_command);
        end
        if (compute_valid != '0) begin
            q_cmask.push_back(compute_valid);
            q_ccmd.push_back(compute_command);
        end
        if (dut0.chk.fail_count != 0)
            abort_run("bound assertion failed");
    end

    initial begin
        void'($urandom(98));
        rst_n = 1'b0;
        run = 1'b0;
        cpu_instr_valid = 1'b0;
        cpu_instr_addr = '0;
        cpu_instr_data = '0;
        dram_rd_data = '0;
        ex_rd_data = '0;
        quiet = 1'b0;
        repeat (2) @(posedge clk);
        quiet <= 1'b1;
        repeat (6) @(posedge clk);
        rst_n <= 1'b1;

        // Blank store while run stays low
        for (int i = 0; i < 256; i++)
            write_entry(i, '0);
        repeat (20) @(posedge clk);

        ////////////////////////////////////////////////////////////////////////////
        // Loads, store and address increments
        base_a = ddr_addr_t'($urandom());
        base_b = ddr_addr_t'($urandom());
        foreach (prog[i])
            prog[i] = '0;
        prog[0] = make_table_instr(1'b0, 1'b1, 3'd0, 3'd2, '0, '0, base_a);
        prog[1] = make_table_instr(1'b0, 1'b1, 3'd0, 3'd4, '0, '0, base_b);
        prog[2] = make_macro_instr(0, 0, 0, 0, 3'd2, 2'b01, 3'd5, 7'h41, '0, '0);
        prog[3] = make_macro_instr(0, 0, 0, 0, 3'd2, 2'b11, 3'd0, 7'h55, '0, '0);
        prog[4] = make_macro_instr(0, 0, 0, 0, 3'd2, 2'b01, 3'd3, 7'h12, '0, '0);
        for (int i = 5; i < 9; i++)
            prog[i] = make_macro_instr(0, 0, 1, 7'd9, 3'd4, 2'b01, 3'd0, 7'h40, '0, '0);
        run_program(7, 0);

        assert (q_ex[0] == 8'h20) else value_mismatch("ex_valid", 64'(q_ex[0]), 64'h20);
        assert (!q_wr[0]) else value_mismatch("dram_wr_en", 64'(q_wr[0]), 64'h0);
        assert (q_addr[0] == base_a)
            else value_mismatch("dram_addr", 64'(q_addr[0]), 64'(base_a));
        assert (q_ex[1] == 8'hff) else value_mismatch("ex_valid", 64'(q_ex[1]), 64'hff);
        assert (q_cmd[1] == 7'h55) else value_mismatch("ex_command", 64'(q_cmd[1]), 64'h55);
        assert (q_wr[2]) else value_mismatch("dram_wr_en", 64'(q_wr[2]), 64'h1);
        assert (q_ex[2] == 8'h08) else value_mismatch("ex_valid", 64'(q_ex[2]), 64'h08);
        for (int j = 0; j < 4; j++) begin
            assert (!q_wr[3 + j])
                else value_mismatch("dram_wr_en", 64'(q_wr[3 + j]), 64'h0);
            assert (q_addr[3 + j] == base_b + ddr_addr_t'(9 * j))
                else value_mismatch("dram_addr", 64'(q_addr[3 + j]),
                                    64'(base_b + ddr_addr_t'(9 * j)));
        end

        ////////////////////////////////////////////////////////////////////////////
        // Two-instruction loop with count 3
        foreach (prog[i])
            prog[i] = '0;
        prog[0] = make_table_instr(1'b1, 1'b0, 3'd1, 3'd0, pc_t'(1), counter_t'(3), '0);
        prog[1] = make_macro_instr(0, 0, 0, 0, 0, 2'b00, 0, '0, 8'ha5, 25'h0abcde);
        prog[2] = make_macro_instr(1, 3'd1, 0, 0, 0, 2'b00, 0, '0, 8'h3c, 25'h1234567);
        run_program(0, 8);

        for (int j = 0; j < 8; j++) begin
            if (j % 2 == 0) begin
                assert (q_cmask[j] == 8'ha5)
                    else value_mismatch("compute_valid", 64'(q_cmask[j]), 64'ha5);
                assert (q_ccmd[j] == 25'h0abcde)
                    else value_mismatch("compute_command", 64'(q_ccmd[j]), 64'h0abcde);
            end else begin
                assert (q_cmask[j] == 8'h3c)
                    else value_mismatch("compute_valid", 64'(q_cmask[j]), 64'h3c);
                assert (q_ccmd[j] == 25'h1234567)
                    else value_mismatch("compute_command", 64'(q_ccmd[j]), 64'h1234567);
            end
        end

        if (dut0.chk.fail_count != 0) begin
            $display("Result: FAILED");
            $fatal(1);
        end else begin
            $display("Result: PASSED");
            $finish;
        end
    end

endmodule

// ==== sources.f ====
+incdir+include
verilog/cim_ctrl_pkg.sv
verilog/instr_fetch.sv
verilog/addr_table_stage.sv
verilog/macro_dispatch.sv
verilog/cim_ctrl_top.sv
sim/cim_ctrl_asserts.sv
sim/tb_cim_ctrl.sv

// ==== verilog/addr_table_stage.sv ====
`timescale 1ns/1ps
`include "cim_ctrl_consts.svh"

module addr_table_stage (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                ld_ddr_valid,
    input  logic [`CIM_DDR_NUM_BITS-1:0]        ld_ddr_index,
    input  cim_ctrl_pkg::ddr_addr_t             ld_ddr_value,
    input  logic                                macro_valid,
    input  logic [`CIM_DDR_NUM_BITS-1:0]        ddr_index,
    input  logic                                incr_en,
    input  logic [`CIM_INCR_BITS-1:0]           incr_amount,
    input  cim_ctrl_pkg::sel_mode_e             sel_mode,
    input  logic [`CIM_MACRO_SEL_BITS-1:0]      macro_sel,
    input  cim_ctrl_pkg::ldst_cmd_t             ldst_cmd,
    input  cim_ctrl_pkg::macro_mask_t           comp_mask,
    input  cim_ctrl_pkg::comp_cmd_t             comp_cmd,
    output logic                                s2_valid,
    output cim_ctrl_pkg::sel_mode_e             s2_sel_mode,
    output logic [`CIM_MACRO_SEL_BITS-1:0]      s2_macro_sel,
    output cim_ctrl_pkg::ldst_cmd_t             s2_ldst_cmd,
    output cim_ctrl_pkg::macro_mask_t           s2_comp_mask,
    output cim_ctrl_pkg::comp_cmd_t             s2_comp_cmd,
    output cim_ctrl_pkg::ddr_addr_t             dram_addr_q
);

    import cim_ctrl_pkg::*;

    localparam int DDR_DEPTH = 1 << `CIM_DDR_NUM_BITS;

    ddr_addr_t      ddr_tab [DDR_DEPTH];
    ddr_addr_t      cur_addr;

    assign cur_addr = ddr_tab[ddr_index];

    ////////////////////////////////////////////////////////////////////////////
    // DRAM address table
    // Increment wins over a load, the two never come in the same cycle anyway
    always_ff @(posedge clk) begin
        if (macro_valid && incr_en)
            ddr_tab[ddr_index] <= cur_addr + ddr_addr_t'(incr_amount);
        else if (ld_ddr_valid)
            ddr_tab[ld_ddr_index] <= ld_ddr_value;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Stage-2 register
    always_ff @(posedge clk) begin
        if (!rst_n)
            s2_valid <= 1'b0;
        else
            s2_valid <= macro_valid;
    end

    // Address as read, before this instruction's increment
    always_ff @(posedge clk) begin
        dram_addr_q  <= cur_addr;
        s2_sel_mode  <= sel_mode;
        s2_macro_sel <= macro_sel;
        s2_ldst_cmd  <= ldst_cmd;
        s2_comp_mask <= comp_mask;
        s2_comp_cmd  <= comp_cmd;
    end

endmodule

// ==== verilog/cim_ctrl_pkg.sv ====
`include "cim_ctrl_consts.svh"

package cim_ctrl_pkg;

    // One 64-bit instruction word
    typedef logic [63:0]                        instr_t;

    // Instruction store index
    typedef logic [`CIM_INSTR_ADDR_BITS-1:0]    pc_t;

    // Loop iteration count
    typedef logic [`CIM_CNT_LEN-1:0]            counter_t;

    typedef logic [`CIM_DDR_ADDR_LEN-1:0]       ddr_addr_t;

    // One column word of a macro, also the DRAM beat
    typedef logic [`CIM_COL_NUM-1:0]            col_data_t;

    // One bit per macro
    typedef logic [`CIM_MACRO_NUM-1:0]          macro_mask_t;

    // Top bit set means load from DRAM into the macro
    typedef logic [`CIM_LDST_CMD_BITS-1:0]      ldst_cmd_t;

    typedef logic [`CIM_COMP_CMD_BITS-1:0]      comp_cmd_t;

    // Load/store macro selection
    typedef enum logic [1:0] {
        NONE       = 2'b00,
        SINGLE     = 2'b01,
        SPLIT_RSVD = 2'b10,
        FULL       = 2'b11
    } sel_mode_e;

endpackage

// ==== verilog/cim_ctrl_top.sv ====
`timescale 1ns/1ps
`include "cim_ctrl_consts.svh"

module cim_ctrl_top (
    input  logic                                        clk,
    input  logic                                        rst_n,
    input  logic                                        run,
    input  logic                                        cpu_instr_valid,
    input  logic [`CIM_INSTR_ADDR_BITS:0]               cpu_instr_addr,
    input  logic [31:0]                                 cpu_instr_data,
    output logic                                        dram_valid,
    output logic                                        dram_wr_en,
    output cim_ctrl_pkg::ddr_addr_t                     dram_addr,
    input  cim_ctrl_pkg::col_data_t                     dram_rd_data,
    output cim_ctrl_pkg::col_data_t                     dram_wr_data,
    output cim_ctrl_pkg::macro_mask_t                   ex_valid,
    output cim_ctrl_pkg::ldst_cmd_t                     ex_command,
    output cim_ctrl_pkg::col_data_t                     ex_wr_data,
    input  cim_ctrl_pkg::col_data_t [`CIM_MACRO_NUM-1:0] ex_rd_data,
    output cim_ctrl_pkg::macro_mask_t                   compute_valid,
    output cim_ctrl_pkg::comp_cmd_t                     compute_command
);

    import cim_ctrl_pkg::*;

    // Fetch to address table
    logic                               ld_ddr_valid;
    logic [`CIM_DDR_NUM_BITS-1:0]       ld_ddr_index;
    ddr_addr_t                          ld_ddr_value;
    logic                               macro_valid;
    logic [`CIM_DDR_NUM_BITS-1:0]       ddr_index;
    logic                               incr_en;
    logic [`CIM_INCR_BITS-1:0]          incr_amount;
    sel_mode_e                          sel_mode;
    logic [`CIM_MACRO_SEL_BITS-1:0]     macro_sel;
    ldst_cmd_t                          ldst_cmd;
    macro_mask_t                        comp_mask;
    comp_cmd_t                          comp_cmd;

    // Address table to dispatch
    logic                               s2_valid;
    sel_mode_e                          s2_sel_mode;
    logic [`CIM_MACRO_SEL_BITS-1:0]     s2_macro_sel;
    ldst_cmd_t                          s2_ldst_cmd;
    macro_mask_t                        s2_comp_mask;
    comp_cmd_t                          s2_comp_cmd;
    ddr_addr_t                          dram_addr_q;

    instr_fetch u_fetch (
        .clk, .rst_n, .cpu_instr_valid, .cpu_instr_addr, .cpu_instr_data, .run,
        .ld_ddr_valid, .ld_ddr_index, .ld_ddr_value,
        .macro_valid, .ddr_index, .incr_en, .incr_amount,
        .sel_mode, .macro_sel, .ldst_cmd, .comp_mask, .comp_cmd
    );

    addr_table_stage u_addr (
        .clk, .rst_n,
        .ld_ddr_valid, .ld_ddr_index, .ld_ddr_value,
        .macro_valid, .ddr_index, .incr_en, .incr_amount,
        .sel_mode, .macro_sel, .ldst_cmd, .comp_mask, .comp_cmd,
        .s2_valid, .s2_sel_mode, .s2_macro_sel, .s2_ldst_cmd,
        .s2_comp_mask, .s2_comp_cmd, .dram_addr_q
    );

    macro_dispatch u_dispatch (
        .clk, .rst_n,
        .s2_valid, .s2_sel_mode, .s2_macro_sel, .s2_ldst_cmd,
        .s2_comp_mask, .s2_comp_cmd, .dram_addr_q,
        .dram_rd_data, .ex_rd_data,
        .dram_valid, .dram_wr_en, .dram_addr, .dram_wr_data,
        .ex_valid, .ex_command, .ex_wr_data,
        .compute_valid, .compute_command
    );

endmodule

// ==== verilog/instr_fetch.sv ====
`timescale 1ns/1ps
`include "cim_ctrl_consts.svh"

module instr_fetch (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                cpu_instr_valid,
    input  logic [`CIM_INSTR_ADDR_BITS:0]       cpu_instr_addr,
    input  logic [31:0]                         cpu_instr_data,
    input  logic                                run,
    output logic                                ld_ddr_valid,
    output logic [`CIM_DDR_NUM_BITS-1:0]        ld_ddr_index,
    output cim_ctrl_pkg::ddr_addr_t             ld_ddr_value,
    output logic                                macro_valid,
    output logic [`CIM_DDR_NUM_BITS-1:0]        ddr_index,
    output logic                                incr_en,
    output logic [`CIM_INCR_BITS-1:0]           incr_amount,
    output cim_ctrl_pkg::sel_mode_e             sel_mode,
    output logic [`CIM_MACRO_SEL_BITS-1:0]      macro_sel,
    output cim_ctrl_pkg::ldst_cmd_t             ldst_cmd,
    output cim_ctrl_pkg::macro_mask_t           comp_mask,
    output cim_ctrl_pkg::comp_cmd_t             comp_cmd
);

    import cim_ctrl_pkg::*;

    localparam int INSTR_DEPTH = 1 << `CIM_INSTR_ADDR_BITS;
    localparam int CNT_DEPTH   = 1 << `CIM_CNT_NUM_BITS;

    instr_t                         instr_mem [INSTR_DEPTH];
    counter_t                       cnt_tab   [CNT_DEPTH];
    pc_t                            stack_tab [CNT_DEPTH];

    pc_t                            pc;
    pc_t                            next_pc;
    instr_t                         instr;
    logic                           is_macro;
    logic                           ld_stk_en;
    logic [`CIM_CNT_NUM_BITS-1:0]   ld_cnt_idx;
    logic [`CIM_CNT_NUM_BITS-1:0]   loop_idx;
    logic                           loop_taken;

    ////////////////////////////////////////////////////////////////////////////
    // CPU writes, one 32-bit half per strobe
    always_ff @(posedge clk) begin
        if (cpu_instr_valid) begin
            if (cpu_instr_addr[0])
                instr_mem[cpu_instr_addr[`CIM_INSTR_ADDR_BITS:1]][63:32] <= cpu_instr_data;
            else
                instr_mem[cpu_instr_addr[`CIM_INSTR_ADDR_BITS:1]][31:0] <= cpu_instr_data;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Fetch and loop-back
    assign instr      = instr_mem[pc];
    assign is_macro   = instr[`CIM_F_MODE];
    assign ld_stk_en  = run & ~is_macro & instr[`CIM_F_LD_STK_EN];
    assign ld_cnt_idx = instr[`CIM_F_LD_CNT_IDX +: `CIM_CNT_NUM_BITS];
    assign loop_idx   = instr[`CIM_F_LOOP_IDX +: `CIM_CNT_NUM_BITS];

    // Nonzero counter jumps back, zero falls through
    assign loop_taken = run & is_macro & instr[`CIM_F_LOOP_EN] & (cnt_tab[loop_idx] != '0);
    assign next_pc    = loop_taken ? stack_tab[loop_idx] : pc + pc_t'(1);

    always_ff @(posedge clk) begin
        if (!rst_n)
            pc <= '0;
        else if (run)
            pc <= next_pc;
    end

    // Stack and counter tables
    always_ff @(posedge clk) begin
        if (ld_stk_en)
            stack_tab[ld_cnt_idx] <= instr[`CIM_F_LD_STACK +: `CIM_INSTR_ADDR_BITS];

        if (loop_taken)
            cnt_tab[loop_idx] <= cnt_tab[loop_idx] - counter_t'(1);
        else if (ld_stk_en)
            cnt_tab[ld_cnt_idx] <= instr[`CIM_F_LD_CNT +: `CIM_CNT_LEN];
    end

    ////////////////////////////////////////////////////////////////////////////
    // Stage-1 register
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ld_ddr_valid <= 1'b0;
            macro_valid  <= 1'b0;
        end else begin
            ld_ddr_valid <= run & ~is_macro & instr[`CIM_F_LD_DDR_EN];
            macro_valid  <= run & is_macro;
        end
    end

    always_ff @(posedge clk) begin
        ld_ddr_index <= instr[`CIM_F_LD_DDR_IDX +: `CIM_DDR_NUM_BITS];
        ld_ddr_value <= instr[`CIM_F_LD_DDR +: `CIM_DDR_ADDR_LEN];
        ddr_index    <= instr[`CIM_F_DDR_IDX +: `CIM_DDR_NUM_BITS];
        incr_en      <= instr[`CIM_F_INCR_EN];
        incr_amount  <= instr[`CIM_F_INCR +: `CIM_INCR_BITS];
        sel_mode     <= sel_mode_e'(instr[`CIM_F_SEL_MODE +: 2]);
        macro_sel    <= instr[`CIM_F_MACRO_SEL +: `CIM_MACRO_SEL_BITS];
        ldst_cmd     <= instr[`CIM_F_LDST_CMD +: `CIM_LDST_CMD_BITS];
        comp_mask    <= instr[`CIM_F_COMP_MASK +: `CIM_MACRO_NUM];
        comp_cmd     <= instr[`CIM_F_COMP_CMD +: `CIM_COMP_CMD_BITS];
    end

endmodule

// ==== verilog/macro_dispatch.sv ====
`timescale 1ns/1ps
`include "cim_ctrl_consts.svh"

module macro_dispatch (
    input  logic                                        clk,
    input  logic                                        rst_n,
    input  logic                                        s2_valid,
    input  cim_ctrl_pkg::sel_mode_e                     s2_sel_mode,
    input  logic [`CIM_MACRO_SEL_BITS-1:0]              s2_macro_sel,
    input  cim_ctrl_pkg::ldst_cmd_t                     s2_ldst_cmd,
    input  cim_ctrl_pkg::macro_mask_t                   s2_comp_mask,
    input  cim_ctrl_pkg::comp_cmd_t                     s2_comp_cmd,
    input  cim_ctrl_pkg::ddr_addr_t                     dram_addr_q,
    input  cim_ctrl_pkg::col_data_t                     dram_rd_data,
    input  cim_ctrl_pkg::col_data_t [`CIM_MACRO_NUM-1:0] ex_rd_data,
    output logic                                        dram_valid,
    output logic                                        dram_wr_en,
    output cim_ctrl_pkg::ddr_addr_t                     dram_addr,
    output cim_ctrl_pkg::col_data_t                     dram_wr_data,
    output cim_ctrl_pkg::macro_mask_t                   ex_valid,
    output cim_ctrl_pkg::ldst_cmd_t                     ex_command,
    output cim_ctrl_pkg::col_data_t                     ex_wr_data,
    output cim_ctrl_pkg::macro_mask_t                   compute_valid,
    output cim_ctrl_pkg::comp_cmd_t                     compute_command
);

    import cim_ctrl_pkg::*;

    macro_mask_t                        sel_mask;
    logic                               is_load;
    logic                               sel_single_q;
    logic [`CIM_MACRO_SEL_BITS-1:0]     macro_idx_q;

    ////////////////////////////////////////////////////////////////////////////
    // Macro selection
    always_comb begin
        case (s2_sel_mode)
            SINGLE:  sel_mask = macro_mask_t'(1) << s2_macro_sel;
            FULL:    sel_mask = '1;
            // Split mode is reserved
            default: sel_mask = '0;
        endcase
    end

    assign is_load = s2_ldst_cmd[`CIM_LDST_CMD_BITS-1];

    ////////////////////////////////////////////////////////////////////////////
    // Stage-3 register
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            dram_valid    <= 1'b0;
            dram_wr_en    <= 1'b0;
            ex_valid      <= '0;
            compute_valid <= '0;
            sel_single_q  <= 1'b0;
        end else begin
            dram_valid    <= s2_valid & (|sel_mask);
            dram_wr_en    <= s2_valid & (|sel_mask) & ~is_load;
            ex_valid      <= s2_valid ? sel_mask : '0;
            compute_valid <= s2_valid ? s2_comp_mask : '0;
            sel_single_q  <= s2_valid & (s2_sel_mode == SINGLE);
        end
    end

    always_ff @(posedge clk) begin
        dram_addr       <= dram_addr_q;
        ex_command      <= s2_ldst_cmd;
        compute_command <= s2_comp_cmd;
        macro_idx_q     <= s2_macro_sel;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Data paths, combinational through the registered selects

    // DRAM beat to the selected macros on a load
    assign ex_wr_data = (dram_valid && !dram_wr_en) ? dram_rd_data : '0;

    // Only a single-macro store returns data to DRAM
    assign dram_wr_data = (sel_single_q && dram_wr_en) ? ex_rd_data[macro_idx_q] : '0;

endmodule
